// File: project.f
source/rv_isa_pkg.sv
source/div_pipe_pkg.sv
source/iter_divider.sv
source/core_divider_manager.sv
source/div_unit_top.sv
verification/div_unit_tb.sv

// File: verification/div_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module div_unit_tb;
  import rv_isa_pkg::*;
  import div_pipe_pkg::*;

  localparam int DIV_STEPS   = XLEN;
  // pushes issued by all tests together
  localparam int OP_COUNT    = 64;
  localparam int CYCLE_LIMIT = OP_COUNT * (DIV_STEPS + 4) + 1000;

  logic     clk = 1'b0;
  logic     rst_n;
  div_req_t req_i;
  logic     push_valid_i;
  logic     push_ready_o;
  logic     wb_stall_i;
  div_id_t  pop_id_i;
  div_res_t rsp_o;

  int      seed;
  int      cycle_cnt = 0;
  int      acc_cnt;
  div_id_t last_id;

  // model of the result table
  logic  exp_valid [ID_COUNT];
  word_t exp_data  [ID_COUNT];

  div_unit_top #(
    .DIV_STEPS(DIV_STEPS)
  ) i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .push_valid_i(push_valid_i),
    .push_ready_o(push_ready_o),
    .wb_stall_i  (wb_stall_i),
    .pop_id_i    (pop_id_i),
    .rsp_o       (rsp_o)
  );

  always #10 clk = ~clk;

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  // expected result by the RV32M rules
  function automatic word_t ref_result(input word_t a, input word_t b, input div_op_t op);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    word_t q;
    word_t r;
    sa = a;
    sb = b;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (!op[0]) begin
      if (a == {1'b1, {(XLEN-1){1'b0}}} && b == '1) begin
        q = a;
        r = '0;
      end else begin
        // SV division truncates toward zero like RISC-V
        q = sa / sb;
        r = sa % sb;
      end
    end else begin
      q = a / b;
      r = a % b;
    end
    return op[1] ? r : q;
  endfunction

  task automatic check_rsp(input logic exp_v, input word_t exp_d);
    assert (rsp_o.valid == exp_v) else begin
      $display("** Error at %0t: rsp_o.valid expected %0b, got %0b", $time, exp_v, rsp_o.valid);
      abort_run();
    end
    if (exp_v) begin
      assert (rsp_o.data == exp_d) else begin
        $display("** Error at %0t: rsp_o.data expected %h, got %h", $time, exp_d, rsp_o.data);
        abort_run();
      end
    end
  endtask

  task automatic push_req(input word_t a, input word_t b, input div_op_t op, input div_id_t id);
    @(negedge clk);
    while (!push_ready_o) begin
      @(negedge clk);
    end
    req_i        = '{dividend: a, divisor: b, op: op, id: id};
    push_valid_i = 1'b1;
    @(negedge clk);
    push_valid_i = 1'b0;
    acc_cnt      = cycle_cnt;
    exp_valid[id] = 1'b0;
    exp_data[id]  = ref_result(a, b, op);
    last_id       = id;
    assert (!push_ready_o) else begin
      $display("** Error at %0t: push_ready_o expected 0, got 1", $time);
      abort_run();
    end
  endtask

  // jitter drives random stall and lookup ids while the division runs
  task automatic wait_idle(input bit jitter);
    int          lat;
    logic [31:0] r;
    while (!push_ready_o) begin
      if (jitter) begin
        r          = $random(seed);
        wb_stall_i = r[0];
        pop_id_i   = r[3:1];
      end
      @(negedge clk);
    end
    lat = cycle_cnt - acc_cnt;
    assert (lat == DIV_STEPS + 2) else begin
      $display("** Error at %0t: push_ready_o latency expected %0d, got %0d",
               $time, DIV_STEPS + 2, lat);
      abort_run();
    end
    exp_valid[last_id] = 1'b1;
    if (jitter) begin
      wb_stall_i = 1'b0;
    end
  endtask

  task automatic read_id(input div_id_t id);
    @(negedge clk);
    wb_stall_i = 1'b0;
    pop_id_i   = id;
    @(negedge clk);
    check_rsp(exp_valid[id], exp_data[id]);
  endtask

  task automatic run_case(input word_t a, input word_t b, input div_op_t op, input div_id_t id);
    push_req(a, b, op, id);
    wait_idle(1'b0);
    read_id(id);
  endtask

  task automatic rand_operands(output word_t a, output word_t b, output div_op_t op);
    logic [31:0] r;
    r  = $random(seed);
    a  = $random(seed);
    b  = $random(seed);
    op = div_op_t'(r[1:0]);
    // mostly small divisors, now and then a zero
    if (r[4:2] == 3'd0) begin
      b = '0;
    end else if (r[5]) begin
      b = b >> r[10:6];
    end
  endtask

  task automatic reset_state_test();
    assert (push_ready_o) else begin
      $display("** Error at %0t: push_ready_o expected 1 after reset, got 0", $time);
      abort_run();
    end
    for (int i = 0; i < ID_COUNT; i++) begin
      read_id(div_id_t'(i));
    end
  endtask

  task automatic directed_ops_test();
    run_case(32'd100, 32'd7, DIV, 3'd0);
    run_case(-32'sd100, 32'd7, DIV, 3'd1);
    run_case(-32'sd100, 32'd7, REM, 3'd2);
    run_case(32'd100, -32'sd7, REM, 3'd3);
    run_case(32'hffff_fff0, 32'd3, DIVU, 3'd4);
    run_case(32'd1000, 32'd33, REMU, 3'd5);
    run_case(-32'sd20, -32'sd6, DIV, 3'd6);
    run_case(-32'sd20, -32'sd6, REM, 3'd7);
  endtask

  task automatic corner_case_test();
    run_case(32'd1234, 32'd0, DIV, 3'd0);
    run_case(32'hdead_beef, 32'd0, DIVU, 3'd1);
    run_case(-32'sd77, 32'd0, REM, 3'd2);
    run_case(32'h8765_4321, 32'd0, REMU, 3'd3);
    run_case(32'h8000_0000, 32'hffff_ffff, DIV, 3'd4);
    run_case(32'h8000_0000, 32'hffff_ffff, REM, 3'd5);
  endtask

  task automatic table_test();
    div_id_t order [ID_COUNT] = '{3'd5, 3'd2, 3'd7, 3'd0, 3'd3, 3'd6, 3'd1, 3'd4};
    word_t   a;
    word_t   b;
    div_op_t op;
    for (int i = 0; i < ID_COUNT; i++) begin
      rand_operands(a, b, op);
      push_req(a, b, op, div_id_t'(i));
      wait_idle(1'b0);
    end
    for (int i = 0; i < ID_COUNT; i++) begin
      read_id(order[i]);
    end
    // a new push to id 3 hides the old result
    rand_operands(a, b, op);
    push_req(a, b, op, 3'd3);
    read_id(3'd3);
    wait_idle(1'b0);
    read_id(3'd3);
  endtask

  task automatic stall_test();
    div_id_t held;
    held = 3'd1;
    read_id(held);
    for (int k = 0; k < 4; k++) begin
      wb_stall_i = 1'b1;
      pop_id_i   = div_id_t'(k + 4);
      @(negedge clk);
      check_rsp(exp_valid[held], exp_data[held]);
    end
    wb_stall_i = 1'b0;

    // id 2 pending, held by the stall until it completes
    push_req(32'd5000, 32'd9, DIVU, 3'd2);
    pop_id_i = 3'd2;
    @(negedge clk);
    check_rsp(1'b0, '0);
    wb_stall_i = 1'b1;
    pop_id_i   = 3'd5;
    while (!push_ready_o) begin
      check_rsp(1'b0, '0);
      @(negedge clk);
    end
    @(negedge clk);
    exp_valid[2] = 1'b1;
    check_rsp(1'b1, exp_data[2]);
    wb_stall_i = 1'b0;
  endtask

  task automatic random_test();
    word_t       a;
    word_t       b;
    div_op_t     op;
    logic [31:0] r;
    for (int i = 0; i < 40; i++) begin
      rand_operands(a, b, op);
      r = $random(seed);
      push_req(a, b, op, div_id_t'(r[2:0]));
      wait_idle(1'b1);
      read_id(div_id_t'(r[2:0]));
    end
  endtask

  initial begin
    seed         = 40130;
    rst_n        = 1'b0;
    req_i        = '0;
    push_valid_i = 1'b0;
    wb_stall_i   = 1'b0;
    pop_id_i     = '0;
    last_id      = '0;
    for (int i = 0; i < ID_COUNT; i++) begin
      exp_valid[i] = 1'b0;
      exp_data[i]  = '0;
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    reset_state_test();
    directed_ops_test();
    corner_case_test();
    table_test();
    stall_test();
    random_test();

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/div_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

module div_unit_top #(
  // one restoring step per result bit
  parameter int DIV_STEPS = $bits(rv_isa_pkg::word_t)
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // execute side push
  input  div_pipe_pkg::div_req_t req_i,
  input  logic                   push_valid_i,
  output logic                   push_ready_o,

  // writeback side lookup
  input  logic                   wb_stall_i,
  input  div_pipe_pkg::div_id_t  pop_id_i,
  output div_pipe_pkg::div_res_t rsp_o
);

  core_divider_manager #(
    .DIV_STEPS(DIV_STEPS)
  ) i_manager (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .push_valid_i(push_valid_i),
    .push_ready_o(push_ready_o),
    .wb_stall_i  (wb_stall_i),
    .pop_id_i    (pop_id_i),
    .rsp_o       (rsp_o)
  );

endmodule

`default_nettype wire

// File: source/core_divider_manager.sv
`timescale 1ns/1ns
`default_nettype none

module core_divider_manager #(
  parameter int DIV_STEPS = $bits(rv_isa_pkg::word_t)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  div_pipe_pkg::div_req_t req_i,
  input  logic                   push_valid_i,
  output logic                   push_ready_o,
  input  logic                   wb_stall_i,
  input  div_pipe_pkg::div_id_t  pop_id_i,
  output div_pipe_pkg::div_res_t rsp_o
);
  import rv_isa_pkg::*;
  import div_pipe_pkg::*;

  typedef enum logic {
    IDLE,
    BUSY
  } mgr_state_t;

  mgr_state_t state_q;

  // division in flight
  div_id_t run_id_q;
  logic    run_rem_q;

  // result table
  logic [ID_COUNT-1:0] valid_q;
  word_t               result_q [ID_COUNT];

  // writeback side
  div_id_t skid_id_q;
  logic    rsp_valid_q;
  word_t   rsp_data_q;

  logic    accept;
  logic    div_signed;
  logic    div_done;
  word_t   div_quo;
  word_t   div_rem;
  div_id_t rd_id;

  assign push_ready_o = (state_q == IDLE);
  assign accept       = push_valid_i && push_ready_o;
  assign div_signed   = (req_i.op == DIV) || (req_i.op == REM);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= BUSY;
          end
        end
        BUSY: begin
          if (div_done) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // remember where the result goes and which half is wanted
  always_ff @(posedge clk) begin
    if (accept) begin
      run_id_q  <= req_i.id;
      run_rem_q <= (req_i.op == REM) || (req_i.op == REMU);
    end
  end

  // accept and done are never in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      if (div_done) begin
        valid_q[run_id_q] <= 1'b1;
      end
      if (accept) begin
        valid_q[req_i.id] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (div_done) begin
      result_q[run_id_q] <= run_rem_q ? div_rem : div_quo;
    end
  end

  // stalled writeback keeps looking at the last id it presented
  assign rd_id = wb_stall_i ? skid_id_q : pop_id_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      skid_id_q   <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (!wb_stall_i) begin
        skid_id_q <= pop_id_i;
      end
      rsp_valid_q <= valid_q[rd_id];
    end
  end

  always_ff @(posedge clk) begin
    rsp_data_q <= result_q[rd_id];
  end

  assign rsp_o = '{valid: rsp_valid_q, data: rsp_data_q};

  iter_divider #(
    .DIV_STEPS(DIV_STEPS)
  ) i_divider (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (accept),
    .dividend_i (req_i.dividend),
    .divisor_i  (req_i.divisor),
    .is_signed_i(div_signed),
    .quotient_o (div_quo),
    .remainder_o(div_rem),
    .done_o     (div_done)
  );

  // a result with no owner would land in a stale table entry
  a_done_when_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    div_done |-> (state_q == BUSY)
  );

  // one division at a time, nothing new until the running one finishes
  a_no_accept_in_flight: assert property (
    @(posedge clk) disable iff (!rst_n)
    accept |=> (!accept until_with div_done)
  );

endmodule

`default_nettype wire

// File: source/iter_divider.sv
`timescale 1ns/1ns
`default_nettype none

module iter_divider #(
  parameter int DIV_STEPS = $bits(rv_isa_pkg::word_t)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  rv_isa_pkg::word_t dividend_i,
  input  rv_isa_pkg::word_t divisor_i,
  input  logic              is_signed_i,
  output rv_isa_pkg::word_t quotient_o,
  output rv_isa_pkg::word_t remainder_o,
  output logic              done_o
);
  import rv_isa_pkg::*;

  localparam int WORD_W    = $bits(word_t);
  localparam int CNT_W     = (DIV_STEPS > 1) ? $clog2(DIV_STEPS) : 1;
  // operands narrower than the word start at the top of the shift register
  localparam int PRE_SHIFT = WORD_W - DIV_STEPS;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FIX
  } div_state_t;

  typedef logic [CNT_W-1:0] step_cnt_t;

  localparam step_cnt_t LAST_STEP = step_cnt_t'(DIV_STEPS - 1);

  div_state_t state_q;
  step_cnt_t  step_q;

  // magnitude datapath
  word_t rem_q;
  word_t quo_q;
  word_t dsr_q;

  // result fix-up flags, captured at start
  logic neg_quo_q;
  logic neg_rem_q;
  logic zero_dsr_q;

  word_t           abs_dividend;
  word_t           abs_divisor;
  logic            dividend_neg;
  logic            divisor_neg;
  logic [WORD_W:0] rem_shift;
  logic [WORD_W:0] trial;
  logic            fits;

  always_comb begin
    dividend_neg = is_signed_i && dividend_i[WORD_W-1];
    divisor_neg  = is_signed_i && divisor_i[WORD_W-1];
    // most negative value maps onto itself, read as unsigned it is correct
    abs_dividend = dividend_neg ? -dividend_i : dividend_i;
    abs_divisor  = divisor_neg ? -divisor_i : divisor_i;

    // bring down the next dividend bit and try the subtraction
    rem_shift = {rem_q, quo_q[WORD_W-1]};
    trial     = rem_shift - {1'b0, dsr_q};
    // borrow out of the top bit means the divisor did not fit
    fits      = !trial[WORD_W];
  end

  // control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      step_q  <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= RUN;
            step_q  <= '0;
          end
        end
        RUN: begin
          step_q <= step_q + 1'b1;
          if (step_q == LAST_STEP) begin
            state_q <= FIX;
          end
        end
        FIX: begin
          state_q <= IDLE;
          done_o  <= 1'b1;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    case (state_q)
      IDLE: begin
        if (start_i) begin
          rem_q      <= '0;
          quo_q      <= abs_dividend << PRE_SHIFT;
          dsr_q      <= abs_divisor;
          zero_dsr_q <= (divisor_i == '0);
          // quotient negative when signs differ, remainder follows dividend
          neg_quo_q  <= dividend_neg ^ divisor_neg;
          neg_rem_q  <= dividend_neg;
        end
      end
      RUN: begin
        rem_q <= fits ? trial[WORD_W-1:0] : rem_shift[WORD_W-1:0];
        quo_q <= {quo_q[WORD_W-2:0], fits};
      end
      FIX: begin
        // divide by zero returns all ones, the remainder already holds
        // the dividend magnitude since every trial fitted
        if (zero_dsr_q) begin
          quotient_o <= '1;
        end else begin
          quotient_o <= neg_quo_q ? -quo_q : quo_q;
        end
        remainder_o <= neg_rem_q ? -rem_q : rem_q;
      end
      default: begin
      end
    endcase
  end

  // the manager counts on a single done per division
  a_done_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    done_o |=> !done_o
  );

endmodule

`default_nettype wire

// File: source/div_pipe_pkg.sv
`default_nettype none

package div_pipe_pkg;

  // tag handed out by issue, one per in-flight instruction
  typedef logic [2:0] div_id_t;

  // one result table entry per possible id
  localparam int ID_COUNT = 2 ** $bits(div_id_t);

  // request from the execute stage
  typedef struct packed {
    rv_isa_pkg::word_t   dividend;
    rv_isa_pkg::word_t   divisor;
    rv_isa_pkg::div_op_t op;
    div_id_t             id;
  } div_req_t;

  // writeback lookup response
  // valid low means the id has no finished result yet
  typedef struct packed {
    logic              valid;
    rv_isa_pkg::word_t data;
  } div_res_t;

endpackage

`default_nettype wire

// File: source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // register width of the integer core
  localparam int XLEN = 32;

  // one data word as it travels between register file and units
  typedef logic [XLEN-1:0] word_t;

  // M extension divide group, funct3[1:0] of the instruction
  // bit 0 low selects a signed op
  // bit 1 high selects the remainder instead of the quotient
  typedef enum logic [1:0] {
    DIV  = 2'b00,
    DIVU = 2'b01,
    REM  = 2'b10,
    REMU = 2'b11
  } div_op_t;

endpackage

`default_nettype wire
